// File: source/rv_consts.svh
// RV64 widths, fixed by the ISA; changing them does not make an RV32 core
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

// data and register width
`define RV_XLEN 64

// instruction word, compressed encodings not supported
`define RV_ILEN 32

// register address width
`define RV_REG_AW 5

// x0 included
`define RV_NUM_REGS 32

`endif

// File: source/isa_pkg.sv
// RV64IM encodings only; no C, A, F, D or Zicsr instructions are described here
`default_nettype none
`include "rv_consts.svh"

package isa_pkg;

  typedef enum logic [6:0] {
    opc_load      = 7'b0000011,
    opc_op_imm    = 7'b0010011,
    opc_auipc     = 7'b0010111,
    opc_op_imm_32 = 7'b0011011,
    opc_store     = 7'b0100011,
    opc_op        = 7'b0110011,
    opc_lui       = 7'b0110111,
    opc_op_32     = 7'b0111011,
    opc_branch    = 7'b1100011,
    opc_jalr      = 7'b1100111,
    opc_jal       = 7'b1101111
  } opcode_e;

  typedef enum logic [2:0] {fmt_none, fmt_i, fmt_u, fmt_s, fmt_b, fmt_j} inst_fmt_e;

  typedef struct packed {
    logic [6:0]            funct7;
    logic [`RV_REG_AW-1:0] rs2;
    logic [`RV_REG_AW-1:0] rs1;
    logic [2:0]            funct3;
    logic [`RV_REG_AW-1:0] rd;
    opcode_e               opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0]           imm;
    logic [`RV_REG_AW-1:0] rs1;
    logic [2:0]            funct3;
    logic [`RV_REG_AW-1:0] rd;
    opcode_e               opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0]            imm_hi;
    logic [`RV_REG_AW-1:0] rs2;
    logic [`RV_REG_AW-1:0] rs1;
    logic [2:0]            funct3;
    logic [4:0]            imm_lo;
    opcode_e               opcode;
  } s_fmt_t;

  typedef struct packed {
    logic                  imm12;
    logic [5:0]            imm10_5;
    logic [`RV_REG_AW-1:0] rs2;
    logic [`RV_REG_AW-1:0] rs1;
    logic [2:0]            funct3;
    logic [3:0]            imm4_1;
    logic                  imm11;
    opcode_e               opcode;
  } b_fmt_t;

  typedef struct packed {
    logic [19:0]           imm;
    logic [`RV_REG_AW-1:0] rd;
    opcode_e               opcode;
  } u_fmt_t;

  typedef struct packed {
    logic                  imm20;
    logic [9:0]            imm10_1;
    logic                  imm11;
    logic [7:0]            imm19_12;
    logic [`RV_REG_AW-1:0] rd;
    opcode_e               opcode;
  } j_fmt_t;

  typedef union packed {
    r_fmt_t r;
    i_fmt_t i;
    s_fmt_t s;
    b_fmt_t b;
    u_fmt_t u;
    j_fmt_t j;
  } inst_u;

  // grouped by class, ctrl_gen decodes the groups as ranges
  typedef enum logic [6:0] {
    op_add, op_sub, op_sll, op_slt, op_sltu, op_xor, op_srl, op_sra, op_or, op_and,
    op_mul, op_mulh, op_mulhsu, op_mulhu, op_div, op_divu, op_rem, op_remu,
    op_addw, op_subw, op_sllw, op_srlw, op_sraw,
    op_mulw, op_divw, op_divuw, op_remw, op_remuw,
    op_addi, op_slti, op_sltiu, op_xori, op_ori, op_andi, op_slli, op_srli, op_srai,
    op_addiw, op_slliw, op_srliw, op_sraiw,
    op_lb, op_lh, op_lw, op_ld, op_lbu, op_lhu, op_lwu,
    op_jalr,
    op_sb, op_sh, op_sw, op_sd,
    op_beq, op_bne, op_blt, op_bge, op_bltu, op_bgeu,
    op_lui, op_auipc, op_jal,
    op_illegal
  } inst_op_e;

endpackage

`default_nettype wire

// File: source/ctrl_pkg.sv
// alu_op code points must match the execute stage ALU; branches carry alu_invalid
`default_nettype none
`include "rv_consts.svh"

package ctrl_pkg;

  typedef enum logic [4:0] {
    alu_add      = 5'd0,
    alu_sub      = 5'd1,
    alu_slt      = 5'd2,
    alu_sltu     = 5'd3,
    alu_xor      = 5'd4,
    alu_and      = 5'd5,
    alu_or       = 5'd6,
    alu_sll      = 5'd7,
    alu_srl      = 5'd8,
    alu_sra      = 5'd9,
    alu_mul      = 5'd10,
    alu_div      = 5'd11,
    alu_divu     = 5'd12,
    alu_rem      = 5'd13,
    alu_remu     = 5'd14,
    alu_copy_imm = 5'd15,
    alu_mulh     = 5'd25,
    alu_mulhsu   = 5'd26,
    alu_mulhu    = 5'd27,
    alu_invalid  = 5'd31
  } alu_op_e;

  typedef enum logic [1:0] {b_rs2, b_imm, b_four} alu_b_src_e;

  // s = sign extended on load, u = zero extended
  typedef enum logic [2:0] {mem_sb, mem_ub, mem_sh, mem_uh, mem_sw, mem_uw, mem_sd, mem_none} mem_op_e;

  typedef enum logic [2:0] {br_jal, br_jalr, br_beq, br_bne, br_blt, br_bge, br_bltu, br_bgeu} br_func_e;

  typedef struct packed {
    alu_op_e    alu_op;
    logic       alu_a_pc;   // operand a is the pc
    alu_b_src_e alu_b_src;
    logic       word_cut;   // 32-bit result, sign extended
    logic       reg_wr;
    logic       mem_to_reg;
    logic       mem_wr;
    logic       mem_re;
    mem_op_e    mem_op;
    logic       br_en;
    br_func_e   br_func;
  } ctrl_t;

  typedef struct packed {
    logic                  wen;
    logic [`RV_REG_AW-1:0] waddr;
    logic [`RV_XLEN-1:0]   wdata;
  } wb_t;

endpackage

`default_nettype wire

// File: source/inst_decoder.sv
// word loads only on i_inst_valid; unmatched words decode as op_illegal, flagged unless all zero
`timescale 1ns/1ns
`default_nettype none
`include "rv_consts.svh"

module inst_decoder (
  input  wire                    i_clk,
  input  wire                    i_rst_n,
  input  wire                    i_inst_valid,
  input  wire [`RV_ILEN-1:0]     i_inst,
  output isa_pkg::inst_u         o_inst,
  output isa_pkg::inst_op_e      o_op,
  output isa_pkg::inst_fmt_e     o_fmt,
  output logic [`RV_REG_AW-1:0]  o_rd,
  output logic [`RV_REG_AW-1:0]  o_rs1,
  output logic [`RV_REG_AW-1:0]  o_rs2,
  output logic                   o_invalid
);

  isa_pkg::inst_u inst_q;
  logic [9:0]     f73;

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      inst_q <= '0;
    end else if (i_inst_valid) begin
      inst_q <= i_inst;
    end
  end

  assign f73 = {inst_q.r.funct7, inst_q.r.funct3};

  always_comb begin
    o_op = isa_pkg::op_illegal;
    case (inst_q.r.opcode)
      isa_pkg::opc_lui:   o_op = isa_pkg::op_lui;
      isa_pkg::opc_auipc: o_op = isa_pkg::op_auipc;
      isa_pkg::opc_jal:   o_op = isa_pkg::op_jal;
      isa_pkg::opc_jalr:
        if (inst_q.i.funct3 == 3'd0)
          o_op = isa_pkg::op_jalr;
      isa_pkg::opc_branch:
        case (inst_q.b.funct3)
          3'd0: o_op = isa_pkg::op_beq;
          3'd1: o_op = isa_pkg::op_bne;
          3'd4: o_op = isa_pkg::op_blt;
          3'd5: o_op = isa_pkg::op_bge;
          3'd6: o_op = isa_pkg::op_bltu;
          3'd7: o_op = isa_pkg::op_bgeu;
          default: ;
        endcase
      isa_pkg::opc_load:
        case (inst_q.i.funct3)
          3'd0: o_op = isa_pkg::op_lb;
          3'd1: o_op = isa_pkg::op_lh;
          3'd2: o_op = isa_pkg::op_lw;
          3'd3: o_op = isa_pkg::op_ld;
          3'd4: o_op = isa_pkg::op_lbu;
          3'd5: o_op = isa_pkg::op_lhu;
          3'd6: o_op = isa_pkg::op_lwu;
          default: ;
        endcase
      isa_pkg::opc_store:
        case (inst_q.s.funct3)
          3'd0: o_op = isa_pkg::op_sb;
          3'd1: o_op = isa_pkg::op_sh;
          3'd2: o_op = isa_pkg::op_sw;
          3'd3: o_op = isa_pkg::op_sd;
          default: ;
        endcase
      isa_pkg::opc_op_imm:
        case (f73) inside
          10'b???????_000: o_op = isa_pkg::op_addi;
          10'b???????_010: o_op = isa_pkg::op_slti;
          10'b???????_011: o_op = isa_pkg::op_sltiu;
          10'b???????_100: o_op = isa_pkg::op_xori;
          10'b???????_110: o_op = isa_pkg::op_ori;
          10'b???????_111: o_op = isa_pkg::op_andi;
          10'b000000?_001: o_op = isa_pkg::op_slli;  // shamt[5] in funct7[0]
          10'b000000?_101: o_op = isa_pkg::op_srli;
          10'b010000?_101: o_op = isa_pkg::op_srai;
          default: ;
        endcase
      isa_pkg::opc_op_imm_32:
        case (f73) inside
          10'b???????_000: o_op = isa_pkg::op_addiw;
          10'b0000000_001: o_op = isa_pkg::op_slliw;
          10'b0000000_101: o_op = isa_pkg::op_srliw;
          10'b0100000_101: o_op = isa_pkg::op_sraiw;
          default: ;
        endcase
      isa_pkg::opc_op:
        case (f73)
          10'b0000000_000: o_op = isa_pkg::op_add;
          10'b0100000_000: o_op = isa_pkg::op_sub;
          10'b0000000_001: o_op = isa_pkg::op_sll;
          10'b0000000_010: o_op = isa_pkg::op_slt;
          10'b0000000_011: o_op = isa_pkg::op_sltu;
          10'b0000000_100: o_op = isa_pkg::op_xor;
          10'b0000000_101: o_op = isa_pkg::op_srl;
          10'b0100000_101: o_op = isa_pkg::op_sra;
          10'b0000000_110: o_op = isa_pkg::op_or;
          10'b0000000_111: o_op = isa_pkg::op_and;
          10'b0000001_000: o_op = isa_pkg::op_mul;
          10'b0000001_001: o_op = isa_pkg::op_mulh;
          10'b0000001_010: o_op = isa_pkg::op_mulhsu;
          10'b0000001_011: o_op = isa_pkg::op_mulhu;
          10'b0000001_100: o_op = isa_pkg::op_div;
          10'b0000001_101: o_op = isa_pkg::op_divu;
          10'b0000001_110: o_op = isa_pkg::op_rem;
          10'b0000001_111: o_op = isa_pkg::op_remu;
          default: ;
        endcase
      isa_pkg::opc_op_32:
        case (f73)
          10'b0000000_000: o_op = isa_pkg::op_addw;
          10'b0100000_000: o_op = isa_pkg::op_subw;
          10'b0000000_001: o_op = isa_pkg::op_sllw;
          10'b0000000_101: o_op = isa_pkg::op_srlw;
          10'b0100000_101: o_op = isa_pkg::op_sraw;
          10'b0000001_000: o_op = isa_pkg::op_mulw;
          10'b0000001_100: o_op = isa_pkg::op_divw;
          10'b0000001_101: o_op = isa_pkg::op_divuw;
          10'b0000001_110: o_op = isa_pkg::op_remw;
          10'b0000001_111: o_op = isa_pkg::op_remuw;
          default: ;
        endcase
      default: ;
    endcase
  end

  always_comb begin
    case (inst_q.r.opcode)
      isa_pkg::opc_load, isa_pkg::opc_op_imm,
      isa_pkg::opc_op_imm_32, isa_pkg::opc_jalr: o_fmt = isa_pkg::fmt_i;
      isa_pkg::opc_store:                        o_fmt = isa_pkg::fmt_s;
      isa_pkg::opc_branch:                       o_fmt = isa_pkg::fmt_b;
      isa_pkg::opc_lui, isa_pkg::opc_auipc:      o_fmt = isa_pkg::fmt_u;
      isa_pkg::opc_jal:                          o_fmt = isa_pkg::fmt_j;
      default:                                   o_fmt = isa_pkg::fmt_none;
    endcase
    if (o_op == isa_pkg::op_illegal)
      o_fmt = isa_pkg::fmt_none;  // no immediate for rejected words
  end

  assign o_inst    = inst_q;
  assign o_rd      = inst_q.r.rd;
  assign o_rs1     = inst_q.r.rs1;
  assign o_rs2     = inst_q.r.rs2;
  assign o_invalid = (o_op == isa_pkg::op_illegal) && (inst_q != '0);

endmodule

`default_nettype wire

// File: source/imm_gen.sv
// R-type and rejected words arrive as fmt_none and give a zero immediate
`timescale 1ns/1ns
`default_nettype none
`include "rv_consts.svh"

module imm_gen (
  input  isa_pkg::inst_u            i_inst,
  input  isa_pkg::inst_fmt_e        i_fmt,
  output logic [`RV_XLEN-1:0]       o_imm
);

  always_comb begin
    case (i_fmt)
      isa_pkg::fmt_i:
        o_imm = {{(`RV_XLEN-12){i_inst.i.imm[11]}}, i_inst.i.imm};
      isa_pkg::fmt_u:
        o_imm = {{(`RV_XLEN-32){i_inst.u.imm[19]}}, i_inst.u.imm, 12'b0};
      isa_pkg::fmt_s:
        o_imm = {{(`RV_XLEN-12){i_inst.s.imm_hi[6]}}, i_inst.s.imm_hi, i_inst.s.imm_lo};
      isa_pkg::fmt_b:
        o_imm = {{(`RV_XLEN-12){i_inst.b.imm12}}, i_inst.b.imm11, i_inst.b.imm10_5,
                 i_inst.b.imm4_1, 1'b0};  // imm12 lands in the sign copies
      isa_pkg::fmt_j:
        o_imm = {{(`RV_XLEN-20){i_inst.j.imm20}}, i_inst.j.imm19_12, i_inst.j.imm11,
                 i_inst.j.imm10_1, 1'b0};
      default:
        o_imm = '0;
    endcase
  end

endmodule

`default_nettype wire

// File: source/ctrl_gen.sv
// relies on the class ordering of isa_pkg::inst_op_e; op_illegal gives the idle bundle
`timescale 1ns/1ns
`default_nettype none

module ctrl_gen (
  input  isa_pkg::inst_op_e i_op,
  output ctrl_pkg::ctrl_t   o_ctrl
);

  logic is_load;

  assign is_load = i_op inside {[isa_pkg::op_lb : isa_pkg::op_lwu]};

  always_comb begin
    case (i_op) inside
      isa_pkg::op_add, isa_pkg::op_addw, isa_pkg::op_addi, isa_pkg::op_addiw,
      isa_pkg::op_auipc, isa_pkg::op_jal, isa_pkg::op_jalr,
      [isa_pkg::op_lb : isa_pkg::op_lwu],
      [isa_pkg::op_sb : isa_pkg::op_sd]:     o_ctrl.alu_op = ctrl_pkg::alu_add;
      isa_pkg::op_lui:                       o_ctrl.alu_op = ctrl_pkg::alu_copy_imm;
      isa_pkg::op_sub, isa_pkg::op_subw:     o_ctrl.alu_op = ctrl_pkg::alu_sub;
      isa_pkg::op_slt, isa_pkg::op_slti:     o_ctrl.alu_op = ctrl_pkg::alu_slt;
      isa_pkg::op_sltu, isa_pkg::op_sltiu:   o_ctrl.alu_op = ctrl_pkg::alu_sltu;
      isa_pkg::op_xor, isa_pkg::op_xori:     o_ctrl.alu_op = ctrl_pkg::alu_xor;
      isa_pkg::op_and, isa_pkg::op_andi:     o_ctrl.alu_op = ctrl_pkg::alu_and;
      isa_pkg::op_or, isa_pkg::op_ori:       o_ctrl.alu_op = ctrl_pkg::alu_or;
      isa_pkg::op_sll, isa_pkg::op_sllw,
      isa_pkg::op_slli, isa_pkg::op_slliw:   o_ctrl.alu_op = ctrl_pkg::alu_sll;
      isa_pkg::op_srl, isa_pkg::op_srlw,
      isa_pkg::op_srli, isa_pkg::op_srliw:   o_ctrl.alu_op = ctrl_pkg::alu_srl;
      isa_pkg::op_sra, isa_pkg::op_sraw,
      isa_pkg::op_srai, isa_pkg::op_sraiw:   o_ctrl.alu_op = ctrl_pkg::alu_sra;
      isa_pkg::op_mul, isa_pkg::op_mulw:     o_ctrl.alu_op = ctrl_pkg::alu_mul;
      isa_pkg::op_mulh:                      o_ctrl.alu_op = ctrl_pkg::alu_mulh;
      isa_pkg::op_mulhsu:                    o_ctrl.alu_op = ctrl_pkg::alu_mulhsu;
      isa_pkg::op_mulhu:                     o_ctrl.alu_op = ctrl_pkg::alu_mulhu;
      isa_pkg::op_div, isa_pkg::op_divw:     o_ctrl.alu_op = ctrl_pkg::alu_div;
      isa_pkg::op_divu, isa_pkg::op_divuw:   o_ctrl.alu_op = ctrl_pkg::alu_divu;
      isa_pkg::op_rem, isa_pkg::op_remw:     o_ctrl.alu_op = ctrl_pkg::alu_rem;
      isa_pkg::op_remu, isa_pkg::op_remuw:   o_ctrl.alu_op = ctrl_pkg::alu_remu;
      default:                               o_ctrl.alu_op = ctrl_pkg::alu_invalid;
    endcase

    o_ctrl.alu_a_pc = i_op inside {isa_pkg::op_jal, isa_pkg::op_jalr, isa_pkg::op_auipc};

    if (i_op inside {isa_pkg::op_jal, isa_pkg::op_jalr})
      o_ctrl.alu_b_src = ctrl_pkg::b_four;  // link address pc + 4
    else if (i_op inside {[isa_pkg::op_addi : isa_pkg::op_lwu], [isa_pkg::op_sb : isa_pkg::op_sd],
                          isa_pkg::op_lui, isa_pkg::op_auipc})
      o_ctrl.alu_b_src = ctrl_pkg::b_imm;
    else
      o_ctrl.alu_b_src = ctrl_pkg::b_rs2;

    o_ctrl.word_cut = i_op inside {[isa_pkg::op_addw : isa_pkg::op_remuw],
                                   [isa_pkg::op_addiw : isa_pkg::op_sraiw]};
    o_ctrl.reg_wr = i_op inside {[isa_pkg::op_add : isa_pkg::op_jalr],
                                 isa_pkg::op_lui, isa_pkg::op_auipc, isa_pkg::op_jal};
    o_ctrl.mem_to_reg = is_load;
    o_ctrl.mem_re     = is_load;
    o_ctrl.mem_wr     = i_op inside {[isa_pkg::op_sb : isa_pkg::op_sd]};

    case (i_op)
      isa_pkg::op_lb, isa_pkg::op_sb: o_ctrl.mem_op = ctrl_pkg::mem_sb;
      isa_pkg::op_lbu:                o_ctrl.mem_op = ctrl_pkg::mem_ub;
      isa_pkg::op_lh, isa_pkg::op_sh: o_ctrl.mem_op = ctrl_pkg::mem_sh;
      isa_pkg::op_lhu:                o_ctrl.mem_op = ctrl_pkg::mem_uh;
      isa_pkg::op_lw, isa_pkg::op_sw: o_ctrl.mem_op = ctrl_pkg::mem_sw;
      isa_pkg::op_lwu:                o_ctrl.mem_op = ctrl_pkg::mem_uw;
      isa_pkg::op_ld, isa_pkg::op_sd: o_ctrl.mem_op = ctrl_pkg::mem_sd;
      default:                        o_ctrl.mem_op = ctrl_pkg::mem_none;
    endcase

    o_ctrl.br_en = i_op inside {[isa_pkg::op_beq : isa_pkg::op_bgeu],
                                isa_pkg::op_jal, isa_pkg::op_jalr};

    case (i_op)
      isa_pkg::op_jalr: o_ctrl.br_func = ctrl_pkg::br_jalr;
      isa_pkg::op_beq:  o_ctrl.br_func = ctrl_pkg::br_beq;
      isa_pkg::op_bne:  o_ctrl.br_func = ctrl_pkg::br_bne;
      isa_pkg::op_blt:  o_ctrl.br_func = ctrl_pkg::br_blt;
      isa_pkg::op_bge:  o_ctrl.br_func = ctrl_pkg::br_bge;
      isa_pkg::op_bltu: o_ctrl.br_func = ctrl_pkg::br_bltu;
      isa_pkg::op_bgeu: o_ctrl.br_func = ctrl_pkg::br_bgeu;
      default:          o_ctrl.br_func = ctrl_pkg::br_jal;  // don't care unless br_en
    endcase
  end

endmodule

`default_nettype wire

// File: source/gpr_file.sv
// x0 reads zero and ignores writes; a write shows on the read ports right after the edge
`timescale 1ns/1ns
`default_nettype none
`include "rv_consts.svh"

module gpr_file (
  input  wire                    i_clk,
  input  wire                    i_rst_n,
  input  wire [`RV_REG_AW-1:0]   i_raddr1,
  input  wire [`RV_REG_AW-1:0]   i_raddr2,
  input  ctrl_pkg::wb_t          i_wb,
  output logic [`RV_XLEN-1:0]    o_rdata1,
  output logic [`RV_XLEN-1:0]    o_rdata2
);

  logic [`RV_XLEN-1:0] regs [1:`RV_NUM_REGS-1];

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      for (int i = 1; i < `RV_NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (i_wb.wen && (i_wb.waddr != '0)) begin
      regs[i_wb.waddr] <= i_wb.wdata;
    end
  end

  assign o_rdata1 = (i_raddr1 == '0) ? '0 : regs[i_raddr1];
  assign o_rdata2 = (i_raddr2 == '0) ? '0 : regs[i_raddr2];

endmodule

`default_nettype wire

// File: source/id_stage.sv
// outputs follow the held word one cycle after i_inst_valid; no stall or flush input
`timescale 1ns/1ns
`default_nettype none
`include "rv_consts.svh"

module id_stage (
  input  wire                    i_clk,
  input  wire                    i_rst_n,
  input  wire                    i_inst_valid,
  input  wire [`RV_ILEN-1:0]     i_inst,
  input  ctrl_pkg::wb_t          i_wb,
  output ctrl_pkg::ctrl_t        o_ctrl,
  output logic [`RV_XLEN-1:0]    o_imm,
  output logic [`RV_REG_AW-1:0]  o_rd,
  output logic [`RV_XLEN-1:0]    o_rs1_data,
  output logic [`RV_XLEN-1:0]    o_rs2_data,
  output logic                   o_invalid
);

  isa_pkg::inst_u        inst;
  isa_pkg::inst_op_e     op;
  isa_pkg::inst_fmt_e    fmt;
  logic [`RV_REG_AW-1:0] rs1;
  logic [`RV_REG_AW-1:0] rs2;

  inst_decoder u_dec (
    .i_clk        (i_clk),
    .i_rst_n      (i_rst_n),
    .i_inst_valid (i_inst_valid),
    .i_inst       (i_inst),
    .o_inst       (inst),
    .o_op         (op),
    .o_fmt        (fmt),
    .o_rd         (o_rd),
    .o_rs1        (rs1),
    .o_rs2        (rs2),
    .o_invalid    (o_invalid)
  );

  imm_gen u_imm (
    .i_inst (inst),
    .i_fmt  (fmt),
    .o_imm  (o_imm)
  );

  ctrl_gen u_ctrl (
    .i_op   (op),
    .o_ctrl (o_ctrl)
  );

  gpr_file u_gpr (
    .i_clk    (i_clk),
    .i_rst_n  (i_rst_n),
    .i_raddr1 (rs1),
    .i_raddr2 (rs2),
    .i_wb     (i_wb),
    .o_rdata1 (o_rs1_data),
    .o_rdata2 (o_rs2_data)
  );

endmodule

`default_nettype wire

// File: tests/tb_vectors.svh
// RV64IM words with expected immediate, bundle and invalid flag; needs the tb encoder functions
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

function automatic void fill_vectors();
  // immediates of both signs per format
  push_i(-64'sd2048, 3'd0, 7'h13, alu_ctrl(ctrl_pkg::alu_add, ctrl_pkg::b_imm, 1'b0));
  push_i(64'sd2047, 3'd0, 7'h13, alu_ctrl(ctrl_pkg::alu_add, ctrl_pkg::b_imm, 1'b0));
  push_u(64'hffff_ffff_8000_0000, 7'h37,
         alu_ctrl(ctrl_pkg::alu_copy_imm, ctrl_pkg::b_imm, 1'b0));
  push_u(64'h0000_0000_1234_5000, 7'h37,
         alu_ctrl(ctrl_pkg::alu_copy_imm, ctrl_pkg::b_imm, 1'b0));
  push_s(-64'sd4, 3'd2, ctrl_pkg::mem_sw);
  push_s(64'sd2037, 3'd2, ctrl_pkg::mem_sw);
  push_b(-64'sd16, 3'd0, ctrl_pkg::br_beq);
  push_b(64'sd4094, 3'd0, ctrl_pkg::br_beq);
  push_j(64'hffff_ffff_fff0_1002);
  push_j(64'h0000_0000_000a_5a5a);
  // alu selection, operand sources and word cut
  push_r(7'h00, 3'd0, 7'h33, alu_ctrl(ctrl_pkg::alu_add, ctrl_pkg::b_rs2, 1'b0));
  push_r(7'h20, 3'd0, 7'h33, alu_ctrl(ctrl_pkg::alu_sub, ctrl_pkg::b_rs2, 1'b0));
  push_i(-64'sd1, 3'd3, 7'h13, alu_ctrl(ctrl_pkg::alu_sltu, ctrl_pkg::b_imm, 1'b0));
  push_i(64'h423, 3'd5, 7'h13, alu_ctrl(ctrl_pkg::alu_sra, ctrl_pkg::b_imm, 1'b0));  // shamt 35
  push_r(7'h00, 3'd0, 7'h3b, alu_ctrl(ctrl_pkg::alu_add, ctrl_pkg::b_rs2, 1'b1));
  push_i(64'h405, 3'd5, 7'h1b, alu_ctrl(ctrl_pkg::alu_sra, ctrl_pkg::b_imm, 1'b1));
  push_r(7'h01, 3'd0, 7'h33, alu_ctrl(ctrl_pkg::alu_mul, ctrl_pkg::b_rs2, 1'b0));
  push_r(7'h01, 3'd2, 7'h33, alu_ctrl(ctrl_pkg::alu_mulhsu, ctrl_pkg::b_rs2, 1'b0));
  push_r(7'h01, 3'd5, 7'h33, alu_ctrl(ctrl_pkg::alu_divu, ctrl_pkg::b_rs2, 1'b0));
  push_r(7'h01, 3'd6, 7'h3b, alu_ctrl(ctrl_pkg::alu_rem, ctrl_pkg::b_rs2, 1'b1));
  push_u(64'h0000_0000_0001_2000, 7'h17, auipc_ctrl());
  push_i(64'sd16, 3'd0, 7'h67, jump_ctrl(ctrl_pkg::br_jalr));
  // loads lb lh lw ld lbu lhu lwu
  push_i(64'sd8, 3'd0, 7'h03, load_ctrl(ctrl_pkg::mem_sb));
  push_i(64'sd8, 3'd1, 7'h03, load_ctrl(ctrl_pkg::mem_sh));
  push_i(64'sd8, 3'd2, 7'h03, load_ctrl(ctrl_pkg::mem_sw));
  push_i(64'sd8, 3'd3, 7'h03, load_ctrl(ctrl_pkg::mem_sd));
  push_i(64'sd8, 3'd4, 7'h03, load_ctrl(ctrl_pkg::mem_ub));
  push_i(64'sd8, 3'd5, 7'h03, load_ctrl(ctrl_pkg::mem_uh));
  push_i(64'sd8, 3'd6, 7'h03, load_ctrl(ctrl_pkg::mem_uw));
  // remaining stores, sw is above
  push_s(64'sd24, 3'd0, ctrl_pkg::mem_sb);
  push_s(-64'sd40, 3'd1, ctrl_pkg::mem_sh);
  push_s(64'sd56, 3'd3, ctrl_pkg::mem_sd);
  // remaining branches
  push_b(64'sd32, 3'd1, ctrl_pkg::br_bne);
  push_b(-64'sd4096, 3'd4, ctrl_pkg::br_blt);
  push_b(64'sd2048, 3'd5, ctrl_pkg::br_bge);
  push_b(-64'sd2, 3'd6, ctrl_pkg::br_bltu);
  push_b(64'sd100, 3'd7, ctrl_pkg::br_bgeu);
  // rejected words, then the zero word which is not flagged
  push_raw(32'h3401_1073, 1'b1);  // csrrw x0, mscratch, x2
  push_raw(32'hffff_ffff, 1'b1);
  push_raw({12'd8, 5'd6, 3'd7, 5'd9, 7'h03}, 1'b1);  // load with funct3 7
  push_raw(32'h0000_0000, 1'b0);
endfunction

`endif

// File: tests/tb_id_stage.sv
// drives id_stage from the vector table and a register sweep; needs the timing mode of the simulator
`timescale 1ns/1ns
`default_nettype none
`include "rv_consts.svh"

module tb_id_stage;

  typedef struct packed {
    logic [`RV_ILEN-1:0] inst;
    logic [`RV_XLEN-1:0] imm;
    ctrl_pkg::ctrl_t     ctrl;
    logic                invalid;
  } vec_t;

  logic                  i_clk;
  logic                  i_rst_n;
  logic                  i_inst_valid;
  logic [`RV_ILEN-1:0]   i_inst;
  ctrl_pkg::wb_t         i_wb;
  ctrl_pkg::ctrl_t       o_ctrl;
  logic [`RV_XLEN-1:0]   o_imm;
  logic [`RV_REG_AW-1:0] o_rd;
  logic [`RV_XLEN-1:0]   o_rs1_data;
  logic [`RV_XLEN-1:0]   o_rs2_data;
  logic                  o_invalid;

  vec_t                vecs [$];
  logic [`RV_XLEN-1:0] reg_model [`RV_NUM_REGS];
  int                  errors = 0;
  logic                table_ready = 1'b0;

  id_stage dut (
    .i_clk        (i_clk),
    .i_rst_n      (i_rst_n),
    .i_inst_valid (i_inst_valid),
    .i_inst       (i_inst),
    .i_wb         (i_wb),
    .o_ctrl       (o_ctrl),
    .o_imm        (o_imm),
    .o_rd         (o_rd),
    .o_rs1_data   (o_rs1_data),
    .o_rs2_data   (o_rs2_data),
    .o_invalid    (o_invalid)
  );

  initial i_clk = 1'b0;
  always #2 i_clk = ~i_clk;  // 4 ns period

  // expected bundles, built from the decode rules
  function automatic ctrl_pkg::ctrl_t idle_ctrl();
    ctrl_pkg::ctrl_t c;
    c = '0;
    c.alu_op    = ctrl_pkg::alu_invalid;
    c.alu_b_src = ctrl_pkg::b_rs2;
    c.mem_op    = ctrl_pkg::mem_none;
    c.br_func   = ctrl_pkg::br_jal;
    return c;
  endfunction

  function automatic ctrl_pkg::ctrl_t alu_ctrl(ctrl_pkg::alu_op_e op, ctrl_pkg::alu_b_src_e b,
                                               logic word_cut);
    ctrl_pkg::ctrl_t c;
    c = idle_ctrl();
    c.alu_op    = op;
    c.alu_b_src = b;
    c.word_cut  = word_cut;
    c.reg_wr    = 1'b1;
    return c;
  endfunction

  function automatic ctrl_pkg::ctrl_t auipc_ctrl();
    ctrl_pkg::ctrl_t c;
    c = alu_ctrl(ctrl_pkg::alu_add, ctrl_pkg::b_imm, 1'b0);
    c.alu_a_pc = 1'b1;
    return c;
  endfunction

  function automatic ctrl_pkg::ctrl_t jump_ctrl(ctrl_pkg::br_func_e f);
    ctrl_pkg::ctrl_t c;
    c = alu_ctrl(ctrl_pkg::alu_add, ctrl_pkg::b_four, 1'b0);  // link value pc + 4
    c.alu_a_pc = 1'b1;
    c.br_en    = 1'b1;
    c.br_func  = f;
    return c;
  endfunction

  function automatic ctrl_pkg::ctrl_t load_ctrl(ctrl_pkg::mem_op_e m);
    ctrl_pkg::ctrl_t c;
    c = alu_ctrl(ctrl_pkg::alu_add, ctrl_pkg::b_imm, 1'b0);
    c.mem_to_reg = 1'b1;
    c.mem_re     = 1'b1;
    c.mem_op     = m;
    return c;
  endfunction

  function automatic ctrl_pkg::ctrl_t store_ctrl(ctrl_pkg::mem_op_e m);
    ctrl_pkg::ctrl_t c;
    c = idle_ctrl();
    c.alu_op    = ctrl_pkg::alu_add;
    c.alu_b_src = ctrl_pkg::b_imm;
    c.mem_wr    = 1'b1;
    c.mem_op    = m;
    return c;
  endfunction

  function automatic ctrl_pkg::ctrl_t branch_ctrl(ctrl_pkg::br_func_e f);
    ctrl_pkg::ctrl_t c;
    c = idle_ctrl();
    c.br_en   = 1'b1;
    c.br_func = f;
    return c;
  endfunction

  function automatic void push_vec(logic [31:0] w, logic [63:0] imm, ctrl_pkg::ctrl_t c,
                                   logic inv);
    vec_t v;
    v.inst    = w;
    v.imm     = imm;
    v.ctrl    = c;
    v.invalid = inv;
    vecs.push_back(v);
  endfunction

  // encoders follow the ISA field layouts, rs1 = x6 and rs2 = x7
  function automatic void push_r(logic [6:0] f7, logic [2:0] f3, logic [6:0] opc,
                                 ctrl_pkg::ctrl_t c);
    push_vec({f7, 5'd7, 5'd6, f3, 5'd5, opc}, '0, c, 1'b0);
  endfunction

  function automatic void push_i(logic [63:0] imm, logic [2:0] f3, logic [6:0] opc,
                                 ctrl_pkg::ctrl_t c);
    push_vec({imm[11:0], 5'd6, f3, 5'd9, opc}, imm, c, 1'b0);
  endfunction

  function automatic void push_s(logic [63:0] imm, logic [2:0] f3, ctrl_pkg::mem_op_e m);
    push_vec({imm[11:5], 5'd7, 5'd6, f3, imm[4:0], 7'h23}, imm, store_ctrl(m), 1'b0);
  endfunction

  function automatic void push_b(logic [63:0] imm, logic [2:0] f3, ctrl_pkg::br_func_e f);
    push_vec({imm[12], imm[10:5], 5'd7, 5'd6, f3, imm[4:1], imm[11], 7'h63}, imm,
             branch_ctrl(f), 1'b0);
  endfunction

  function automatic void push_u(logic [63:0] imm, logic [6:0] opc, ctrl_pkg::ctrl_t c);
    push_vec({imm[31:12], 5'd10, opc}, imm, c, 1'b0);
  endfunction

  function automatic void push_j(logic [63:0] imm);
    push_vec({imm[20], imm[10:1], imm[11], imm[19:12], 5'd1, 7'h6f}, imm,
             jump_ctrl(ctrl_pkg::br_jal), 1'b0);
  endfunction

  function automatic void push_raw(logic [31:0] w, logic inv);
    push_vec(w, '0, idle_ctrl(), inv);
  endfunction

  function automatic logic [31:0] add_word(logic [4:0] r);
    return {7'd0, r, r, 3'd0, 5'd3, 7'h33};  // add x3, r, r
  endfunction

  `include "tb_vectors.svh"

  task automatic check_ctrl(input ctrl_pkg::ctrl_t got, input ctrl_pkg::ctrl_t exp,
                            input string what);
    if (got !== exp) begin
      errors++;
      $display("** Error at %0t ns: %s got %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_word(input logic [`RV_XLEN-1:0] got, input logic [`RV_XLEN-1:0] exp,
                            input string what);
    if (got !== exp) begin
      errors++;
      $display("** Error at %0t ns: %s got %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      errors++;
      $display("** Error at %0t ns: %s got %b, expected %b", $time, what, got, exp);
    end
  endtask

  initial begin
    wait (table_ready);
    #((vecs.size() + 2 * `RV_NUM_REGS + 20) * 4);
    $display("timeout: the tests did not finish in the expected number of cycles");
    $display("TB FAILED");
    $finish;
  end

  initial begin
    logic [`RV_XLEN-1:0] data;
    string               tag;
    void'($urandom(32'had17_bb9f));
    i_rst_n      <= 1'b0;
    i_inst_valid <= 1'b0;
    i_inst       <= '0;
    i_wb         <= '0;
    fill_vectors();
    table_ready = 1'b1;
    repeat (5) @(posedge i_clk);
    i_rst_n <= 1'b1;
    @(negedge i_clk);
    check_ctrl(o_ctrl, idle_ctrl(), "o_ctrl after reset");
    check_flag(o_invalid, 1'b0, "o_invalid after reset");
    check_word(o_imm, '0, "o_imm after reset");
    check_word(o_rs1_data, '0, "o_rs1_data after reset");
    check_word(o_rs2_data, '0, "o_rs2_data after reset");

    // one word per cycle, each checked the cycle after it is loaded
    @(posedge i_clk);
    i_inst_valid <= 1'b1;
    i_inst       <= vecs[0].inst;
    for (int k = 0; k < vecs.size(); k++) begin
      @(posedge i_clk);
      if (k + 1 < vecs.size()) begin
        i_inst <= vecs[k+1].inst;
      end else begin
        i_inst_valid <= 1'b0;
        i_inst       <= ~vecs[k].inst;  // must not reach the held word
      end
      @(negedge i_clk);
      tag = $sformatf(" for word %h", vecs[k].inst);
      check_ctrl(o_ctrl, vecs[k].ctrl, {"o_ctrl", tag});
      check_word(o_imm, vecs[k].imm, {"o_imm", tag});
      check_word(64'(o_rd), 64'(vecs[k].inst[11:7]), {"o_rd", tag});
      check_flag(o_invalid, vecs[k].invalid, {"o_invalid", tag});
      // no write-back yet, every register still holds its reset value
      check_word(o_rs1_data, '0, {"o_rs1_data", tag});
      check_word(o_rs2_data, '0, {"o_rs2_data", tag});
    end

    // with i_inst_valid low the last word stays in place
    @(posedge i_clk);
    @(negedge i_clk);
    check_ctrl(o_ctrl, vecs[vecs.size()-1].ctrl, "o_ctrl held while not valid");
    check_flag(o_invalid, vecs[vecs.size()-1].invalid, "o_invalid held while not valid");

    for (int r = 0; r < `RV_NUM_REGS; r++) begin
      @(posedge i_clk);
      data = {$urandom, $urandom};
      i_wb <= '{wen: 1'b1, waddr: r[4:0], wdata: data};
      reg_model[r] = (r == 0) ? '0 : data;  // x0 drops the write
    end
    @(posedge i_clk);
    i_wb         <= '0;
    i_inst_valid <= 1'b1;
    i_inst       <= add_word(5'd0);
    for (int r = 0; r < `RV_NUM_REGS; r++) begin
      @(posedge i_clk);
      if (r + 1 < `RV_NUM_REGS)
        i_inst <= add_word(5'(r + 1));
      else
        i_inst_valid <= 1'b0;
      @(negedge i_clk);
      tag = $sformatf(" reading x%0d", r);
      check_word(o_rs1_data, reg_model[r], {"o_rs1_data", tag});
      check_word(o_rs2_data, reg_model[r], {"o_rs2_data", tag});
    end

    $display("checks done with %0d errors", errors);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: build.f
+incdir+source
+incdir+tests
source/isa_pkg.sv
source/ctrl_pkg.sv
source/inst_decoder.sv
source/imm_gen.sv
source/ctrl_gen.sv
source/gpr_file.sv
source/id_stage.sv
tests/tb_id_stage.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --timescale 1ns/1ns -j 0
TOP       ?= tb_id_stage
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := TB PASSED

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
